//--- source/host_bus_pkg.sv
// host bus package with command codes, status words, host command/response and wishbone structs
package host_bus_pkg;

	// host command codes, one word each
	localparam logic [31:0] CMD_PING     = 32'h0000_0000;
	localparam logic [31:0] CMD_WRITE    = 32'h0000_0001;
	localparam logic [31:0] CMD_READ     = 32'h0000_0002;
	// codes 3 to 6 were the stream commands
	localparam logic [31:0] CMD_RW_FLAGS = 32'h0000_0007;

	// data word answered to a ping
	localparam logic [31:0] S_PING_RESP = 32'h0000_1EAF;

	// status for a command the master does not know
	localparam logic [31:0] STATUS_BAD_COMMAND = 32'h0000_DEAD;

	// command word set from the host input handler
	typedef struct packed {
		logic [31:0] command;
		logic [31:0] address;
		logic [31:0] data;
	} host_cmd_t;

	// response word set for the host output handler
	// status is the inverted command on success
	typedef struct packed {
		logic [31:0] status;
		logic [31:0] address;
		logic [31:0] data;
	} host_resp_t;

	// master to slave side of a wishbone bus
	typedef struct packed {
		// byte address
		logic [31:0] adr;
		// write data
		logic [31:0] dat;
		logic        we;
		logic        cyc;
		logic        stb;
		// byte lane selects
		logic [3:0]  sel;
	} wb_req_t;

	// slave to master side
	typedef struct packed {
		// read data, valid with ack
		logic [31:0] dat;
		logic        ack;
	} wb_rsp_t;

endpackage

//--- source/wishbone_master.sv
// host command master that decodes host commands, runs wishbone cycles and returns responses
`timescale 1ns/1ps

module wishbone_master
	import host_bus_pkg::*;
#(
	// identity of the host port, matches the arbiter grant bit
	parameter int MASTER_ID = 0
) (
	input  logic       clk,
	input  logic       rst,

	// host input handler side
	input  logic       in_ready_i,
	input  host_cmd_t  in_cmd_i,
	output logic       master_ready_o,

	// host output handler side
	input  logic       out_ready_i,
	output host_resp_t out_resp_o,
	output logic       out_en_o,

	// wishbone side
	output wb_req_t    wb_req_o,
	input  wb_rsp_t    wb_rsp_i
);

	typedef enum logic [1:0] {
		// waiting for a host command
		ST_IDLE,
		// wishbone cycle in flight
		ST_BUS,
		// response presented to the host
		ST_RESP
	} state_t;

	state_t      state_q;
	host_cmd_t   cmd_q;
	host_resp_t  resp_q;
	logic [31:0] flags_q;
	logic        bus_req_q;
	logic        accept;
	logic        is_bus_cmd;
	logic        bus_done;

	// strobe only counts while idle
	assign accept = in_ready_i && (state_q == ST_IDLE);

	// write and read go out on the bus, everything else answers locally
	assign is_bus_cmd = (in_cmd_i.command == CMD_WRITE) || (in_cmd_i.command == CMD_READ);

	// single transfer ends on ack
	assign bus_done = (state_q == ST_BUS) && wb_rsp_i.ack;

	assign master_ready_o = (state_q == ST_IDLE);
	assign out_en_o = (state_q == ST_RESP);
	assign out_resp_o = resp_q;

	// request comes straight from the latched command
	// full word access, all byte lanes
	assign wb_req_o = '{
		adr: cmd_q.address,
		dat: cmd_q.data,
		we:  (cmd_q.command == CMD_WRITE),
		cyc: bus_req_q,
		stb: bus_req_q,
		sel: 4'hf
	};

	// control fsm and flags register
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q <= ST_IDLE;
			bus_req_q <= 1'b0;
			flags_q <= '0;
		end else begin
			case (state_q)
				ST_IDLE: begin
					if (accept) begin
						if (is_bus_cmd) begin
							bus_req_q <= 1'b1;
							state_q <= ST_BUS;
						end else begin
							// ping, flags and bad commands answer next cycle
							state_q <= ST_RESP;
						end
						// swap in the new flags, old value goes out in the response
						if (in_cmd_i.command == CMD_RW_FLAGS) begin
							flags_q <= in_cmd_i.data;
						end
					end
				end
				ST_BUS: begin
					// cyc and stb drop on the ack edge
					if (wb_rsp_i.ack) begin
						bus_req_q <= 1'b0;
						state_q <= ST_RESP;
					end
				end
				ST_RESP: begin
					// held until the host takes it
					if (out_ready_i) begin
						state_q <= ST_IDLE;
					end
				end
				default: begin
					state_q <= ST_IDLE;
				end
			endcase
		end
	end

	// latched command and response words
	always_ff @(posedge clk) begin
		if (accept) begin
			cmd_q <= in_cmd_i;
			case (in_cmd_i.command)
				CMD_PING: begin
					resp_q <= '{status: ~in_cmd_i.command, address: '0, data: S_PING_RESP};
				end
				CMD_RW_FLAGS: begin
					resp_q <= '{status: ~in_cmd_i.command, address: in_cmd_i.address,
						data: flags_q};
				end
				CMD_WRITE, CMD_READ: begin
					// data filled in when the bus answers
					resp_q.status <= ~in_cmd_i.command;
					resp_q.address <= in_cmd_i.address;
				end
				default: begin
					resp_q <= '{status: STATUS_BAD_COMMAND, address: in_cmd_i.address,
						data: '0};
				end
			endcase
		end else if (bus_done) begin
			// read returns bus data, write echoes what was written
			resp_q.data <= (cmd_q.command == CMD_READ) ? wb_rsp_i.dat : cmd_q.data;
		end
	end

	// host must wait for the ready level before strobing
	a_strobe_when_ready: assert property (@(posedge clk) disable iff (rst)
		in_ready_i |-> master_ready_o)
		else $error("master %0d: command strobe while not ready", MASTER_ID);

	// ack only comes back inside this master's own cycle
	a_ack_in_cycle: assert property (@(posedge clk) disable iff (rst)
		wb_rsp_i.ack |-> wb_req_o.cyc && wb_req_o.stb)
		else $error("master %0d: ack outside a bus cycle", MASTER_ID);

endmodule

//--- source/wb_arbiter.sv
// round-robin arbiter that grants one of two wishbone masters the shared bus
`timescale 1ns/1ps

module wb_arbiter
	import host_bus_pkg::*;
(
	input  logic    clk,
	input  logic    rst,

	// master side
	input  wb_req_t m0_req_i,
	input  wb_req_t m1_req_i,
	output wb_rsp_t m0_rsp_o,
	output wb_rsp_t m1_rsp_o,

	// slave side
	output wb_req_t slv_req_o,
	input  wb_rsp_t slv_rsp_i
);

	// one bit per master, all zero when nobody owns the bus
	logic [1:0] grant_q;
	logic [1:0] grant_d;
	// owner of the last grant, high for master 1
	logic       last_q;
	logic       bus_idle;

	// idle once the owner lets go of cyc
	assign bus_idle = !(grant_q[0] && m0_req_i.cyc) && !(grant_q[1] && m1_req_i.cyc);

	// next owner
	always_comb begin
		grant_d = 2'b00;
		if (m0_req_i.cyc && m1_req_i.cyc) begin
			// both asking, the one skipped last time wins
			grant_d = last_q ? 2'b01 : 2'b10;
		end else if (m0_req_i.cyc) begin
			grant_d = 2'b01;
		end else if (m1_req_i.cyc) begin
			grant_d = 2'b10;
		end
	end

	// grant only moves while the bus is idle
	always_ff @(posedge clk) begin
		if (rst) begin
			grant_q <= 2'b00;
			// master 0 first after reset
			last_q <= 1'b1;
		end else if (bus_idle) begin
			grant_q <= grant_d;
			if (grant_d[0]) begin
				last_q <= 1'b0;
			end else if (grant_d[1]) begin
				last_q <= 1'b1;
			end
		end
	end

	// request mux, quiet bus without an owner
	always_comb begin
		slv_req_o = '0;
		if (grant_q[0]) begin
			slv_req_o = m0_req_i;
		end else if (grant_q[1]) begin
			slv_req_o = m1_req_i;
		end
	end

	// read data fans out, ack only to the owner
	assign m0_rsp_o = '{dat: slv_rsp_i.dat, ack: slv_rsp_i.ack && grant_q[0]};
	assign m1_rsp_o = '{dat: slv_rsp_i.dat, ack: slv_rsp_i.ack && grant_q[1]};

	// an ack from the slave belongs to one owner that still holds its cycle
	a_ack_to_owner: assert property (@(posedge clk) disable iff (rst)
		slv_rsp_i.ack |-> $onehot(grant_q) && (grant_q[0] ? m0_req_i.cyc : m1_req_i.cyc))
		else $error("arbiter: ack without a granted master in a cycle");

endmodule

//--- source/wb_ram.sv
// wishbone RAM slave with byte lane writes and a one-cycle acknowledge
`timescale 1ns/1ps

module wb_ram
	import host_bus_pkg::*;
#(
	// word address bits
	parameter int RAM_ADDR_WIDTH = 8
) (
	input  logic    clk,
	input  logic    rst,
	input  wb_req_t wb_req_i,
	output wb_rsp_t wb_rsp_o
);

	localparam int DEPTH = 2 ** RAM_ADDR_WIDTH;

	logic [31:0]               mem [DEPTH];
	logic [31:0]               rdata_q;
	logic [RAM_ADDR_WIDTH-1:0] word_addr;
	logic                      ack_q;
	logic                      access;

	// drop the byte offset
	assign word_addr = wb_req_i.adr[RAM_ADDR_WIDTH+1:2];

	// first cycle of a strobe, the ack cycle itself does not count
	assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

	// ack pulse
	always_ff @(posedge clk) begin
		if (rst) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= access;
		end
	end

	// storage and read port
	always_ff @(posedge clk) begin
		if (access) begin
			if (wb_req_i.we) begin
				// masked per byte lane
				for (int i = 0; i < 4; i++) begin
					if (wb_req_i.sel[i]) begin
						mem[word_addr][8*i +: 8] <= wb_req_i.dat[8*i +: 8];
					end
				end
			end
			// read data lines up with ack
			rdata_q <= mem[word_addr];
		end
	end

	assign wb_rsp_o = '{dat: rdata_q, ack: ack_q};

	// a strobe stays up until it is acknowledged
	a_stb_held: assert property (@(posedge clk) disable iff (rst)
		wb_req_i.cyc && wb_req_i.stb && !wb_rsp_o.ack |=> wb_req_i.cyc && wb_req_i.stb)
		else $error("ram: strobe dropped before ack");

endmodule

//--- source/host_bridge_top.sv
// host bridge top with two command masters, the bus arbiter and the RAM slave
`timescale 1ns/1ps

module host_bridge_top
	import host_bus_pkg::*;
#(
	parameter int RAM_ADDR_WIDTH = 8
) (
	input  logic       clk,
	input  logic       rst,

	// host port 0
	input  logic       in_ready_0_i,
	input  host_cmd_t  in_cmd_0_i,
	output logic       master_ready_0_o,
	input  logic       out_ready_0_i,
	output host_resp_t out_resp_0_o,
	output logic       out_en_0_o,

	// host port 1
	input  logic       in_ready_1_i,
	input  host_cmd_t  in_cmd_1_i,
	output logic       master_ready_1_o,
	input  logic       out_ready_1_i,
	output host_resp_t out_resp_1_o,
	output logic       out_en_1_o
);

	// master to arbiter
	wb_req_t m0_req;
	wb_req_t m1_req;
	wb_rsp_t m0_rsp;
	wb_rsp_t m1_rsp;

	// arbiter to ram
	wb_req_t slv_req;
	wb_rsp_t slv_rsp;

	// port 0 master, grant bit 0
	wishbone_master #(
		.MASTER_ID(0)
	) u_master_0 (
		.clk            (clk),
		.rst            (rst),
		.in_ready_i     (in_ready_0_i),
		.in_cmd_i       (in_cmd_0_i),
		.master_ready_o (master_ready_0_o),
		.out_ready_i    (out_ready_0_i),
		.out_resp_o     (out_resp_0_o),
		.out_en_o       (out_en_0_o),
		.wb_req_o       (m0_req),
		.wb_rsp_i       (m0_rsp)
	);

	// port 1 master, grant bit 1
	wishbone_master #(
		.MASTER_ID(1)
	) u_master_1 (
		.clk            (clk),
		.rst            (rst),
		.in_ready_i     (in_ready_1_i),
		.in_cmd_i       (in_cmd_1_i),
		.master_ready_o (master_ready_1_o),
		.out_ready_i    (out_ready_1_i),
		.out_resp_o     (out_resp_1_o),
		.out_en_o       (out_en_1_o),
		.wb_req_o       (m1_req),
		.wb_rsp_i       (m1_rsp)
	);

	wb_arbiter u_arbiter (
		.clk       (clk),
		.rst       (rst),
		.m0_req_i  (m0_req),
		.m1_req_i  (m1_req),
		.m0_rsp_o  (m0_rsp),
		.m1_rsp_o  (m1_rsp),
		.slv_req_o (slv_req),
		.slv_rsp_i (slv_rsp)
	);

	wb_ram #(
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
	) u_ram (
		.clk      (clk),
		.rst      (rst),
		.wb_req_i (slv_req),
		.wb_rsp_o (slv_rsp)
	);

endmodule

//--- verification/host_bridge_tasks.svh
// driver, compare and directed test tasks plus the xorshift random source
`ifndef HOST_BRIDGE_TASKS_SVH
`define HOST_BRIDGE_TASKS_SVH

// xorshift32 step on the shared state
function automatic logic [31:0] next_random();
	logic [31:0] x;
	x = rand_state;
	x ^= x << 13;
	x ^= x >> 17;
	x ^= x << 5;
	rand_state = x;
	return x;
endfunction

// word aligned byte address inside the RAM
function automatic logic [31:0] random_addr();
	return next_random() & ((2**RAM_ADDR_WIDTH - 1) << 2);
endfunction

// one clock, then 1 ns for outputs to settle and inputs to change
task automatic next_cycle();
	@(posedge clk);
	#1;
endtask

task automatic compare_word(input string name, input logic [31:0] exp, input logic [31:0] act);
	if (act !== exp) begin
		$display("FAILED %s: expected %h, got %h", name, exp, act);
		error_count++;
	end
endtask

task automatic compare_resp(input string name, input host_resp_t exp, input host_resp_t act);
	if (act !== exp) begin
		$display("FAILED %s: expected %h, got %h", name, exp, act);
		error_count++;
	end
endtask

task automatic compare_bit(input string name, input logic exp, input logic act);
	if (act !== exp) begin
		$display("FAILED %s: expected %h, got %h", name, exp, act);
		error_count++;
	end
endtask

// wait for ready, strobe once, wait for the response
// latency counts edges from the strobe to out_en
task automatic send_cmd(input int port, input host_cmd_t cmd, output host_resp_t resp,
	output int latency);
	while (master_ready[port] !== 1'b1) next_cycle();
	in_cmd[port] = cmd;
	in_ready[port] = 1'b1;
	next_cycle();
	in_ready[port] = 1'b0;
	latency = 1;
	while (out_en[port] !== 1'b1) begin
		next_cycle();
		latency++;
	end
	resp = out_resp[port];
endtask

task automatic write_word(input int port, input logic [31:0] addr, input logic [31:0] data);
	host_resp_t resp;
	int         lat;
	send_cmd(port, '{command: CMD_WRITE, address: addr, data: data}, resp, lat);
	compare_word("out_resp.status", ~CMD_WRITE, resp.status);
	compare_word("out_resp.address", addr, resp.address);
	model[addr >> 2] = data;
endtask

// read back and check against the model
task automatic read_check(input int port, input logic [31:0] addr);
	host_resp_t resp;
	int         lat;
	send_cmd(port, '{command: CMD_READ, address: addr, data: '0}, resp, lat);
	compare_resp("out_resp", '{status: ~CMD_READ, address: addr, data: model[addr >> 2]}, resp);
endtask

task automatic test_ping();
	host_resp_t resp;
	int         lat;
	for (int p = 0; p < 2; p++) begin
		send_cmd(p, '{command: CMD_PING, address: next_random(), data: next_random()}, resp, lat);
		compare_resp("out_resp", '{status: ~CMD_PING, address: '0, data: S_PING_RESP}, resp);
		compare_word("ping latency", 1, lat);
	end
endtask

task automatic test_write_read();
	logic [31:0] addrs [8];
	foreach (addrs[i]) begin
		addrs[i] = random_addr();
		write_word(0, addrs[i], next_random());
	end
	foreach (addrs[i]) read_check(1, addrs[i]);
endtask

task automatic test_flags();
	logic [31:0] flags_a;
	logic [31:0] flags_b;
	host_resp_t  resp;
	int          lat;
	flags_a = next_random();
	flags_b = next_random();
	send_cmd(0, '{command: CMD_RW_FLAGS, address: 32'h10, data: flags_a}, resp, lat);
	compare_resp("out_resp", '{status: ~CMD_RW_FLAGS, address: 32'h10, data: '0}, resp);
	send_cmd(0, '{command: CMD_RW_FLAGS, address: 32'h14, data: flags_b}, resp, lat);
	compare_resp("out_resp", '{status: ~CMD_RW_FLAGS, address: 32'h14, data: flags_a}, resp);
	// port 1 keeps its own flags, still zero
	send_cmd(1, '{command: CMD_RW_FLAGS, address: 32'h18, data: flags_b}, resp, lat);
	compare_resp("out_resp", '{status: ~CMD_RW_FLAGS, address: 32'h18, data: '0}, resp);
endtask

task automatic test_concurrent_writes();
	logic [31:0] addr_0;
	logic [31:0] addr_1;
	logic [31:0] data_0;
	logic [31:0] data_1;
	addr_0 = random_addr();
	// neighbouring word, never the same one
	addr_1 = addr_0 ^ 32'h4;
	data_0 = next_random();
	data_1 = next_random();
	// both ports ready so the strobes land on the same edge
	while (master_ready[0] !== 1'b1 || master_ready[1] !== 1'b1) next_cycle();
	fork
		write_word(0, addr_0, data_0);
		write_word(1, addr_1, data_1);
	join
	read_check(0, addr_1);
	read_check(1, addr_0);
endtask

task automatic test_backpressure();
	logic [31:0] addr;
	host_resp_t  held;
	host_resp_t  exp_resp;
	int          lat;
	addr = random_addr();
	write_word(1, addr, next_random());
	// let the write response go before holding the next one
	while (master_ready[1] !== 1'b1) next_cycle();
	out_ready[1] = 1'b0;
	exp_resp = '{status: ~CMD_READ, address: addr, data: model[addr >> 2]};
	send_cmd(1, '{command: CMD_READ, address: addr, data: '0}, held, lat);
	compare_resp("out_resp_1_o", exp_resp, held);
	repeat (5) begin
		next_cycle();
		compare_bit("out_en_1_o", 1'b1, out_en[1]);
		compare_bit("master_ready_1_o", 1'b0, master_ready[1]);
		compare_resp("out_resp_1_o", exp_resp, out_resp[1]);
	end
	// consumed on the next edge
	out_ready[1] = 1'b1;
	next_cycle();
	compare_bit("out_en_1_o", 1'b0, out_en[1]);
	compare_bit("master_ready_1_o", 1'b1, master_ready[1]);
endtask

task automatic test_bad_command();
	logic [31:0] addr;
	host_resp_t  resp;
	int          lat;
	for (int p = 0; p < 2; p++) begin
		addr = random_addr();
		write_word(p, addr, next_random());
		// an old stream code, then one never defined
		send_cmd(p, '{command: (p == 0) ? 32'h3 : 32'h100, address: addr,
			data: ~model[addr >> 2]}, resp, lat);
		compare_word("out_resp.status", STATUS_BAD_COMMAND, resp.status);
		read_check(1 - p, addr);
	end
endtask

`endif

//--- verification/host_bridge_tb.sv
// host bridge testbench top with clock, reset, DUT instance, watchdog and test sequence
`timescale 1ns/1ps

module host_bridge_tb
	import host_bus_pkg::*;
();

	localparam int RAM_ADDR_WIDTH = 8;
	localparam int NUM_TESTS = 6;
	localparam int RESET_CYCLES = 10;

	logic       clk;
	logic       rst;
	// host port signals, indexed by port number
	logic       in_ready [2];
	host_cmd_t  in_cmd [2];
	logic       master_ready [2];
	logic       out_ready [2];
	host_resp_t out_resp [2];
	logic       out_en [2];

	int          error_count;
	// xorshift state
	logic [31:0] rand_state;
	// expected RAM contents, one entry per word
	logic [31:0] model [2**RAM_ADDR_WIDTH];

	`include "host_bridge_tasks.svh"

	host_bridge_top #(
		.RAM_ADDR_WIDTH(RAM_ADDR_WIDTH)
	) UUT (
		.clk              (clk),
		.rst              (rst),
		.in_ready_0_i     (in_ready[0]),
		.in_cmd_0_i       (in_cmd[0]),
		.master_ready_0_o (master_ready[0]),
		.out_ready_0_i    (out_ready[0]),
		.out_resp_0_o     (out_resp[0]),
		.out_en_0_o       (out_en[0]),
		.in_ready_1_i     (in_ready[1]),
		.in_cmd_1_i       (in_cmd[1]),
		.master_ready_1_o (master_ready[1]),
		.out_ready_1_i    (out_ready[1]),
		.out_resp_1_o     (out_resp[1]),
		.out_en_1_o       (out_en[1])
	);

	// 20 ns period
	always #10 clk = ~clk;

	// watchdog, about 200 cycles per test
	initial begin
		repeat (RESET_CYCLES + NUM_TESTS * 200) @(posedge clk);
		$display("timeout: the tests did not finish in %0d cycles", NUM_TESTS * 200);
		$display("errors: %0d", error_count);
		$display("=== FAIL ===");
		$finish;
	end

	// test sequence
	initial begin
		clk = 1'b0;
		rst = 1'b1;
		error_count = 0;
		rand_state = 32'h9956;
		for (int p = 0; p < 2; p++) begin
			in_ready[p] = 1'b0;
			in_cmd[p] = '0;
			// responses consumed at once unless a test holds them
			out_ready[p] = 1'b1;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		// idle levels straight after reset
		for (int p = 0; p < 2; p++) begin
			compare_bit("out_en_o", 1'b0, out_en[p]);
			compare_bit("master_ready_o", 1'b1, master_ready[p]);
		end

		test_ping();
		test_write_read();
		test_flags();
		test_concurrent_writes();
		test_backpressure();
		test_bad_command();

		$display("errors: %0d", error_count);
		if (error_count == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- host_bridge.f
+incdir+verification
source/host_bus_pkg.sv
source/wishbone_master.sv
source/wb_arbiter.sv
source/wb_ram.sv
source/host_bridge_top.sv
verification/host_bridge_tb.sv
